// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		op_load   = 7'b0000011,
		op_imm    = 7'b0010011,
		op_store  = 7'b0100011,
		op_reg    = 7'b0110011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	// operations the EX stage ALU knows
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_e;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== logic/pipe_ifs.sv ====
`default_nettype none

// decoded instruction held in the ID/EX register
interface idex_if;
	import rv_pkg::*;

	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic alu_src;
	logic branch;
	alu_op_e alu_op;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm;
	word_t pc_val;

	modport source (
		output reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch,
		output alu_op, rs1, rs2, rd, rs1_val, rs2_val, imm, pc_val
	);

	modport sink (
		input reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch,
		input alu_op, rs1, rs2, rd, rs1_val, rs2_val, imm, pc_val
	);
endinterface

// results held in the EX/MEM register
interface exmem_if;
	import rv_pkg::*;

	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic branch;
	logic zero;
	word_t alu_result;
	word_t store_data;
	reg_addr_t rd;
	word_t branch_target;

	modport source (
		output reg_write, mem_read, mem_write, mem_to_reg, branch, zero,
		output alu_result, store_data, rd, branch_target
	);

	modport sink (
		input reg_write, mem_read, mem_write, mem_to_reg, branch, zero,
		input alu_result, store_data, rd, branch_target
	);
endinterface

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`default_nettype none

module fetch_stage #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input wire clock,
	input wire reset,
	input wire stall,
	input wire jump_taken,
	input wire rv_pkg::word_t jump_target,
	input wire branch_taken,
	input wire rv_pkg::word_t branch_target,
	input wire rv_pkg::word_t instr,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t ifid_instr,
	output rv_pkg::word_t ifid_pc
);
	import rv_pkg::*;

	word_t next_pc;
	logic flush;

	// beq from MEM wins over jal from ID
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jump_taken) begin
			next_pc = jump_target;
		end else begin
			next_pc = pc + xlen'(4);
		end
	end

	assign flush = branch_taken | jump_taken;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (flush || !stall) begin
			pc <= next_pc;
		end
	end

	// a flushed slot in IF/ID becomes a nop
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifid_instr <= nop_instr;
		end else if (flush) begin
			ifid_instr <= nop_instr;
		end else if (!stall) begin
			ifid_instr <= instr;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			ifid_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
	input wire clock,
	input wire reset,
	input wire rv_pkg::reg_addr_t rs1,
	input wire rv_pkg::reg_addr_t rs2,
	output rv_pkg::word_t rs1_val,
	output rv_pkg::word_t rs2_val,
	input wire wb_en,
	input wire rv_pkg::reg_addr_t wb_rd,
	input wire rv_pkg::word_t wb_data
);
	import rv_pkg::*;

	// x0 has no storage
	word_t regs [1:31];
	logic wr_active;

	assign wr_active = wb_en && (wb_rd != '0);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_active) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// value being written in WB is passed straight to ID
	assign rs1_val = (rs1 == '0) ? '0 :
		(wr_active && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(wr_active && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

module decode_stage (
	input wire clock,
	input wire reset,
	input wire rv_pkg::word_t ifid_instr,
	input wire rv_pkg::word_t ifid_pc,
	input wire branch_taken,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	input wire rv_pkg::word_t rs1_val,
	input wire rv_pkg::word_t rs2_val,
	output logic stall,
	output logic jump_taken,
	output rv_pkg::word_t jump_target,
	idex_if.source idex
);
	import rv_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rd;
	word_t imm_i, imm_s, imm_b, imm_j, imm_sel;
	logic reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch;
	logic uses_rs1, uses_rs2, is_jal;
	alu_op_e alu_op;

	assign opcode = opcode_e'(ifid_instr[6:0]);
	assign rd = ifid_instr[11:7];
	assign funct3 = ifid_instr[14:12];
	assign rs1 = ifid_instr[19:15];
	assign rs2 = ifid_instr[24:20];
	assign funct7 = ifid_instr[31:25];

	assign imm_i = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
	assign imm_s = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
	assign imm_b = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
		ifid_instr[30:25], ifid_instr[11:8], 1'b0};
	assign imm_j = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
		ifid_instr[20], ifid_instr[30:21], 1'b0};

	// main control
	always_comb begin
		{reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch} = '0;
		{uses_rs1, uses_rs2, is_jal} = '0;
		alu_op = alu_add;
		imm_sel = '0;
		case (opcode)
			op_reg: begin
				reg_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				case (funct3)
					3'b000: alu_op = funct7[5] ? alu_sub : alu_add;
					3'b010: alu_op = alu_slt;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			op_imm: begin
				{reg_write, alu_src, uses_rs1} = 3'b111;
				imm_sel = imm_i;
			end
			op_load: begin
				{reg_write, mem_read, mem_to_reg, alu_src, uses_rs1} = 5'b11111;
				imm_sel = imm_i;
			end
			op_store: begin
				{mem_write, alu_src, uses_rs1, uses_rs2} = 4'b1111;
				imm_sel = imm_s;
			end
			op_branch: begin
				{branch, uses_rs1, uses_rs2} = 3'b111;
				alu_op = alu_sub;
				imm_sel = imm_b;
			end
			op_jal: begin
				// link value is pc + 4 through the ALU
				{reg_write, alu_src, is_jal} = 3'b111;
				imm_sel = xlen'(4);
			end
			default: begin
			end
		endcase
	end

	assign jump_taken = is_jal;
	assign jump_target = ifid_pc + imm_j;

	// load in EX feeding a source of the instruction in ID
	assign stall = idex.mem_read && (idex.rd != '0) &&
		((uses_rs1 && idex.rd == rs1) || (uses_rs2 && idex.rd == rs2));

	always_ff @(posedge clock or negedge reset) begin
		if (!reset || stall || branch_taken) begin
			idex.reg_write <= 1'b0;
			idex.mem_read <= 1'b0;
			idex.mem_write <= 1'b0;
			idex.mem_to_reg <= 1'b0;
			idex.alu_src <= 1'b0;
			idex.branch <= 1'b0;
			idex.alu_op <= alu_add;
			idex.rs1 <= '0;
			idex.rs2 <= '0;
			idex.rd <= '0;
		end else begin
			idex.reg_write <= reg_write;
			idex.mem_read <= mem_read;
			idex.mem_write <= mem_write;
			idex.mem_to_reg <= mem_to_reg;
			idex.alu_src <= alu_src;
			idex.branch <= branch;
			idex.alu_op <= alu_op;
			// jal reads no register, x0 keeps forwarding off
			idex.rs1 <= is_jal ? '0 : rs1;
			idex.rs2 <= is_jal ? '0 : rs2;
			idex.rd <= rd;
		end
	end

	always_ff @(posedge clock) begin
		idex.rs1_val <= is_jal ? ifid_pc : rs1_val;
		idex.rs2_val <= rs2_val;
		idex.imm <= imm_sel;
		idex.pc_val <= ifid_pc;
	end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input wire clock,
	input wire reset,
	input wire branch_taken,
	idex_if.sink idex,
	input wire wb_en,
	input wire rv_pkg::reg_addr_t wb_rd,
	input wire rv_pkg::word_t wb_data,
	exmem_if.source exmem
);
	import rv_pkg::*;

	word_t fwd_a, fwd_b, op_b;
	word_t alu_result;
	word_t branch_target;

	// newest producer first, x0 never forwarded
	function automatic word_t forward(input reg_addr_t src, input word_t reg_val);
		word_t result;
		result = reg_val;
		if (src != '0) begin
			if (exmem.reg_write && exmem.rd == src) begin
				result = exmem.alu_result;
			end else if (wb_en && wb_rd == src) begin
				result = wb_data;
			end
		end
		return result;
	endfunction

	assign fwd_a = forward(idex.rs1, idex.rs1_val);
	assign fwd_b = forward(idex.rs2, idex.rs2_val);
	assign op_b = idex.alu_src ? idex.imm : fwd_b;

	always_comb begin
		case (idex.alu_op)
			alu_add: alu_result = fwd_a + op_b;
			alu_sub: alu_result = fwd_a - op_b;
			alu_and: alu_result = fwd_a & op_b;
			alu_or:  alu_result = fwd_a | op_b;
			alu_xor: alu_result = fwd_a ^ op_b;
			alu_slt: alu_result = xlen'($signed(fwd_a) < $signed(op_b));
			default: alu_result = fwd_a + op_b;
		endcase
	end

	assign branch_target = idex.pc_val + idex.imm;

	// control half of EX/MEM is emptied on a taken beq
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exmem.reg_write <= 1'b0;
			exmem.mem_read <= 1'b0;
			exmem.mem_write <= 1'b0;
			exmem.mem_to_reg <= 1'b0;
			exmem.branch <= 1'b0;
			exmem.rd <= '0;
		end else if (branch_taken) begin
			exmem.reg_write <= 1'b0;
			exmem.mem_read <= 1'b0;
			exmem.mem_write <= 1'b0;
			exmem.mem_to_reg <= 1'b0;
			exmem.branch <= 1'b0;
			exmem.rd <= '0;
		end else begin
			exmem.reg_write <= idex.reg_write;
			exmem.mem_read <= idex.mem_read;
			exmem.mem_write <= idex.mem_write;
			exmem.mem_to_reg <= idex.mem_to_reg;
			exmem.branch <= idex.branch;
			exmem.rd <= idex.rd;
		end
	end

	always_ff @(posedge clock) begin
		exmem.zero <= (alu_result == '0);
		exmem.alu_result <= alu_result;
		// store data also goes through forwarding
		exmem.store_data <= fwd_b;
		exmem.branch_target <= branch_target;
	end

endmodule

`default_nettype wire

// ==== logic/mem_wb_stage.sv ====
`default_nettype none

module mem_wb_stage (
	input wire clock,
	input wire reset,
	exmem_if.sink exmem,
	output logic branch_taken,
	output rv_pkg::word_t branch_target,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_wdata,
	output logic data_wen,
	output logic data_ren,
	input wire rv_pkg::word_t data_rdata,
	output logic wb_en,
	output rv_pkg::reg_addr_t wb_rd,
	output rv_pkg::word_t wb_data
);
	import rv_pkg::*;

	logic wb_mem_to_reg;
	word_t wb_load_data;
	word_t wb_alu_result;

	// beq compares through the sub in EX
	assign branch_taken = exmem.branch & exmem.zero;
	assign branch_target = exmem.branch_target;

	assign data_addr = exmem.alu_result;
	assign data_wdata = exmem.store_data;
	assign data_wen = exmem.mem_write;
	assign data_ren = exmem.mem_read;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_en <= 1'b0;
			wb_rd <= '0;
			wb_mem_to_reg <= 1'b0;
		end else begin
			wb_en <= exmem.reg_write;
			wb_rd <= exmem.rd;
			wb_mem_to_reg <= exmem.mem_to_reg;
		end
	end

	always_ff @(posedge clock) begin
		wb_load_data <= data_rdata;
		wb_alu_result <= exmem.alu_result;
	end

	assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input wire clock,
	input wire reset,
	output rv_pkg::word_t pc,
	input wire rv_pkg::word_t instr,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_wdata,
	output logic data_wen,
	output logic data_ren,
	input wire rv_pkg::word_t data_rdata
);
	import rv_pkg::*;

	logic stall;
	logic branch_taken;
	logic jump_taken;
	word_t jump_target;
	word_t branch_target;
	word_t ifid_instr;
	word_t ifid_pc;
	reg_addr_t rs1, rs2;
	word_t rs1_val, rs2_val;
	logic wb_en;
	reg_addr_t wb_rd;
	word_t wb_data;

	idex_if idex ();
	exmem_if exmem ();

	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.jump_taken(jump_taken),
		.jump_target(jump_target),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.instr(instr),
		.pc(pc),
		.ifid_instr(ifid_instr),
		.ifid_pc(ifid_pc)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.ifid_instr(ifid_instr),
		.ifid_pc(ifid_pc),
		.branch_taken(branch_taken),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.stall(stall),
		.jump_taken(jump_taken),
		.jump_target(jump_target),
		.idex(idex.source)
	);

	reg_file u_regs (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	execute_stage u_execute (
		.clock(clock),
		.reset(reset),
		.branch_taken(branch_taken),
		.idex(idex.sink),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.exmem(exmem.source)
	);

	mem_wb_stage u_mem_wb (
		.clock(clock),
		.reset(reset),
		.exmem(exmem.sink),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`default_nettype none

module clock_gen (
	input wire reset_req,
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ns;

	int hold;

	initial begin
		clock = 1'b0;
		reset = 1'b0;
		hold = 4;
	end

	// 100 ns period
	always #50 clock = ~clock;

	// reset stays low while requested, then for 5 more edges
	always @(posedge clock) begin
		if (reset_req) begin
			reset <= 1'b0;
			hold <= 4;
		end else if (hold > 0) begin
			hold <= hold - 1;
		end else begin
			reset <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`default_nettype none

module mem_model (
	input wire clock,
	input wire rv_pkg::word_t pc,
	output rv_pkg::word_t instr,
	input wire rv_pkg::word_t data_addr,
	input wire rv_pkg::word_t data_wdata,
	input wire data_wen,
	input wire data_ren,
	output rv_pkg::word_t data_rdata,
	input wire clear,
	input wire load_en,
	input wire load_imem,
	input wire rv_pkg::word_t load_addr,
	input wire rv_pkg::word_t load_data
);
	timeunit 1ns;
	timeprecision 1ns;
	import rv_pkg::*;

	localparam int mem_words = 1024;
	localparam int log_depth = 64;

	word_t imem [0:mem_words-1];
	word_t dmem [0:mem_words-1];

	// every store in the order it reached the bus
	word_t log_addr [0:log_depth-1];
	word_t log_data [0:log_depth-1];
	int log_count;

	assign instr = imem[pc[11:2]];
	assign data_rdata = data_ren ? dmem[data_addr[11:2]] : '0;

	always @(posedge clock) begin
		if (clear) begin
			for (int i = 0; i < mem_words; i++) begin
				imem[i] <= nop_instr;
				// untouched data words carry their own address
				dmem[i] <= 32'ha5a5_0000 ^ (word_t'(i) << 2);
			end
			log_count <= 0;
		end else if (load_en) begin
			if (load_imem) begin
				imem[load_addr[11:2]] <= load_data;
			end else begin
				dmem[load_addr[11:2]] <= load_data;
			end
		end else if (data_wen) begin
			dmem[data_addr[11:2]] <= data_wdata;
			if (log_count < log_depth) begin
				log_addr[log_count] <= data_addr;
				log_data[log_count] <= data_wdata;
			end
			log_count <= log_count + 1;
		end
	end

endmodule

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import rv_pkg::*;

	localparam word_t reset_pc = '0;
	localparam word_t end_addr = 32'h0000_0ffc;
	localparam int max_cycles = 500;
	localparam int reset_cycles = 20;
	localparam string cases_file = "tb/program_cases.txt";

	logic clock;
	logic reset;
	logic reset_req;
	word_t pc;
	word_t instr;
	word_t data_addr;
	word_t data_wdata;
	logic data_wen;
	logic data_ren;
	word_t data_rdata;
	logic clear;
	logic load_en;
	logic load_imem;
	word_t load_addr;
	word_t load_data;

	// current case as read from the file
	string case_name;
	word_t prog_addr [$];
	word_t prog_word [$];
	word_t init_addr [$];
	word_t init_word [$];
	word_t exp_addr [$];
	word_t exp_data [$];

	int error_count;
	int pass_count;
	int fail_count;

	clock_gen clock0 (
		.reset_req(reset_req),
		.clock(clock),
		.reset(reset)
	);

	mem_model mem0 (
		.clock(clock),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata),
		.clear(clear),
		.load_en(load_en),
		.load_imem(load_imem),
		.load_addr(load_addr),
		.load_data(load_data)
	);

	rv_core #(
		.reset_pc(reset_pc)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata)
	);

	task automatic check_value(input string test, input string what,
		input word_t expected, input word_t actual);
		if (expected !== actual) begin
			error_count++;
			$display("ERR %s %s: expected %08h, actual %08h", test, what, expected, actual);
		end
	endtask

	// called right after a rising edge, returns on the next one
	task automatic load_word(input logic to_imem, input word_t addr, input word_t value);
		load_en <= 1'b1;
		load_imem <= to_imem;
		load_addr <= addr;
		load_data <= value;
		@(posedge clock);
	endtask

	function automatic bit end_store_seen();
		int last;
		last = mem0.log_count - 1;
		return last >= 0 && mem0.log_addr[last] == end_addr;
	endfunction

	task automatic run_case();
		int errors_before;
		int wait_count;
		errors_before = error_count;

		// core stays in reset while both memories are filled
		@(posedge clock);
		reset_req <= 1'b1;
		clear <= 1'b1;
		@(posedge clock);
		clear <= 1'b0;
		foreach (prog_addr[i]) begin
			load_word(1'b1, prog_addr[i], prog_word[i]);
		end
		foreach (init_addr[i]) begin
			load_word(1'b0, init_addr[i], init_word[i]);
		end
		load_en <= 1'b0;
		reset_req <= 1'b0;

		wait_count = 0;
		while (reset !== 1'b1 && wait_count < reset_cycles) begin
			@(negedge clock);
			wait_count++;
		end
		if (reset !== 1'b1) begin
			error_count++;
			$display("case %s: reset was not released within %0d cycles",
				case_name, reset_cycles);
		end else begin
			check_value(case_name, "pc after reset", reset_pc, pc);
			check_value(case_name, "data_wen after reset", '0, word_t'(data_wen));
			check_value(case_name, "data_ren after reset", '0, word_t'(data_ren));

			wait_count = 0;
			while (!end_store_seen() && wait_count < max_cycles) begin
				@(negedge clock);
				wait_count++;
			end
			if (!end_store_seen()) begin
				error_count++;
				$display("case %s timed out, no store to %08h within %0d cycles",
					case_name, end_addr, max_cycles);
			end else begin
				check_value(case_name, "store count", word_t'(exp_addr.size()),
					word_t'(mem0.log_count));
				foreach (exp_addr[i]) begin
					if (i < mem0.log_count) begin
						check_value(case_name, $sformatf("store %0d address", i),
							exp_addr[i], mem0.log_addr[i]);
						check_value(case_name, $sformatf("store %0d data", i),
							exp_data[i], mem0.log_data[i]);
					end
				end
			end
		end

		if (error_count == errors_before) begin
			pass_count++;
			$display("case %s passed", case_name);
		end else begin
			fail_count++;
			$display("case %s failed", case_name);
		end
	endtask

	initial begin
		int fd;
		int n;
		string line;
		string tag;
		word_t field_a;
		word_t field_b;

		reset_req = 1'b0;
		clear = 1'b0;
		load_en = 1'b0;
		load_imem = 1'b0;
		load_addr = '0;
		load_data = '0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;

		fd = $fopen(cases_file, "r");
		if (fd == 0) begin
			$display("could not open the cases file %s", cases_file);
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				tag = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s", tag);
				end else begin
					n = 0;
				end
				if (n > 0) begin
					if (tag == "case") begin
						n = $sscanf(line, "%s %s", tag, case_name);
						prog_addr.delete();
						prog_word.delete();
						init_addr.delete();
						init_word.delete();
						exp_addr.delete();
						exp_data.delete();
					end else if (tag == "end") begin
						run_case();
					end else begin
						n = $sscanf(line, "%s %h %h", tag, field_a, field_b);
						if (n != 3) begin
							fail_count++;
							$display("unreadable line in the cases file: %s", line);
						end else if (tag == "i") begin
							prog_addr.push_back(field_a);
							prog_word.push_back(field_b);
						end else if (tag == "d") begin
							init_addr.push_back(field_a);
							init_word.push_back(field_b);
						end else if (tag == "s") begin
							exp_addr.push_back(field_a);
							exp_data.push_back(field_b);
						end else begin
							fail_count++;
							$display("unknown tag %s in the cases file", tag);
						end
					end
				end
			end
			$fclose(fd);

			$display("cases passed: %0d, cases failed: %0d", pass_count, fail_count);
			if (fail_count == 0 && pass_count > 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/pipe_ifs.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
tb/clock_gen.sv
tb/mem_model.sv
tb/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
CASES     := tb/program_cases.txt
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

$(LOG): $(SIM) $(CASES)
	$(SIM) | tee $(LOG)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

check: $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/program_cases.txt ====
# case <name> | i <byte addr> <instr word> | d <byte addr> <data word>
# s <byte addr> <value> expected store in program order | end runs the case
case alu_chain
i 00 00500093
i 04 ff408113
i 08 001101b3
i 0c 40118233
i 10 001272b3
i 14 0022e333
i 18 001343b3
i 1c 0013a433
i 20 0070a4b3
i 24 10202023
i 28 10302223
i 2c 10402423
i 30 10502623
i 34 10602823
i 38 10702a23
i 3c 10802c23
i 40 10902e23
i 44 7fe00f93
i 48 7e0faf23
s 100 fffffff9
s 104 fffffffe
s 108 fffffff9
s 10c 00000001
s 110 fffffff9
s 114 fffffffc
s 118 00000001
s 11c 00000000
s ffc 00000000
end
case load_use
i 00 20002083
i 04 00108133
i 08 20402183
i 0c 00310233
i 10 10202023
i 14 10402223
i 18 20802283
i 1c 10502423
i 20 7fe00f93
i 24 7e0faf23
d 200 00000123
d 204 00000456
d 208 80000001
s 100 00000246
s 104 0000069c
s 108 80000001
s ffc 00000000
end
case beq_paths
i 00 00700093
i 04 00700113
i 08 00208863
i 0c 10102023
i 10 10102223
i 14 10102423
i 18 00900193
i 1c 00308863
i 20 10302623
i 24 10102823
i 28 10202a23
i 2c 7fe00f93
i 30 7e0faf23
s 10c 00000009
s 110 00000007
s 114 00000007
s ffc 00000000
end
case jal_link
i 00 00100093
i 04 008002ef
i 08 10102023
i 0c 10502223
i 10 00128333
i 14 10602423
i 18 7fe00f93
i 1c 7e0faf23
s 104 00000008
s 108 00000009
s ffc 00000000
end
